/* rtl/axil_reg_slave.sv */
`default_nettype none

`include "hello_params.svh"

module axil_reg_slave (
  input  wire logic                     clk_main_a0,
  input  wire logic                     rst_main_n_sync,
  input  wire logic                     awvalid,
  input  wire logic [`HELLO_ADDR_W-1:0] awaddr,
  output logic                          awready,
  input  wire logic                     wvalid,
  input  wire logic [`HELLO_DATA_W-1:0] wdata,
  output logic                          wready,
  output logic                          bvalid,
  input  wire logic                     bready,
  input  wire logic                     arvalid,
  input  wire logic [`HELLO_ADDR_W-1:0] araddr,
  output logic                          arready,
  output logic                          rvalid,
  output logic [`HELLO_DATA_W-1:0]      rdata,
  input  wire logic                     rready,
  reg_bus_if.master                     bus
);

  logic                     wr_active;
  logic [`HELLO_ADDR_W-1:0] wr_addr_q;
  logic                     rd_req_q;
  logic [`HELLO_ADDR_W-1:0] rd_addr_q;

  // --------------------
  // Write channel
  // --------------------
  // One write in flight, open from AW until B completes
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_active <= 1'b0;
      wr_addr_q <= '0;
    end else if (wr_active && bvalid && bready) begin
      wr_active <= 1'b0;
    end else if (!wr_active && awvalid) begin
      wr_active <= 1'b1;
      wr_addr_q <= awaddr;
    end
  end

  assign awready = !wr_active;
  // Data beat taken only while no response is pending
  assign wready  = wr_active && !bvalid && wvalid;

  // Response raised the cycle after the data beat
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      bvalid <= 1'b0;
    end else if (bvalid && bready) begin
      bvalid <= 1'b0;
    end else if (wready) begin
      bvalid <= 1'b1;
    end
  end

  // Register write strobe on the accepted beat
  assign bus.wr_en   = wready;
  assign bus.wr_addr = wr_addr_q;
  assign bus.wr_data = wdata;

  // --------------------
  // Read channel
  // --------------------
  assign arready = !rd_req_q && !rvalid;

  // Address stage, one cycle after the AR handshake
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_req_q  <= 1'b0;
      rd_addr_q <= '0;
    end else begin
      rd_req_q <= arvalid && arready;
      if (arvalid && arready) begin
        rd_addr_q <= araddr;
      end
    end
  end

  assign bus.rd_en   = rd_req_q;
  assign bus.rd_addr = rd_addr_q;

  // Response stage, valid held until the master takes it
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rvalid <= 1'b0;
    end else if (rvalid && rready) begin
      rvalid <= 1'b0;
    end else if (rd_req_q) begin
      rvalid <= 1'b1;
    end
  end

  // Register file data stays put until the next read strobe
  // No new strobe while rvalid is up, zero outside the valid window
  assign rdata = rvalid ? bus.rd_data : '0;

endmodule

`default_nettype wire

/* rtl/cl_hello_top.sv */
`default_nettype none

`include "hello_params.svh"

module cl_hello_top (
  input  wire logic                     clk_main_a0,
  input  wire logic                     rst_main_n_sync,
  // AXI4-Lite register port
  input  wire logic                     awvalid,
  input  wire logic [`HELLO_ADDR_W-1:0] awaddr,
  output logic                          awready,
  input  wire logic                     wvalid,
  input  wire logic [`HELLO_DATA_W-1:0] wdata,
  output logic                          wready,
  output logic                          bvalid,
  input  wire logic                     bready,
  input  wire logic                     arvalid,
  input  wire logic [`HELLO_ADDR_W-1:0] araddr,
  output logic                          arready,
  output logic                          rvalid,
  output logic [`HELLO_DATA_W-1:0]      rdata,
  input  wire logic                     rready,
  // Virtual switches and LEDs
  input  wire logic [`HELLO_LED_W-1:0]  vdip,
  output logic [`HELLO_LED_W-1:0]       vled
);

  import hello_pkg::*;

  cnt_ctrl_t               cnt_ctrl;
  cnt_status_t             cnt_status;
  logic [`HELLO_LED_W-1:0] led_src;

  reg_bus_if reg_bus (
    .clk_main_a0 (clk_main_a0)
  );

  // --------------------
  // Bus front end
  // --------------------
  axil_reg_slave i_axil_reg_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rready          (rready),
    .bus             (reg_bus.master)
  );

  hello_regs i_hello_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .bus             (reg_bus.slave),
    .cnt_status      (cnt_status),
    .cnt_ctrl        (cnt_ctrl),
    .led_src         (led_src)
  );

  // LED and counter functions
  led_status i_led_status (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .led_src         (led_src),
    .vdip            (vdip),
    .vled            (vled)
  );

  tick_counter i_tick_counter (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .ctrl            (cnt_ctrl),
    .status          (cnt_status)
  );

endmodule

`default_nettype wire

/* rtl/hello_params.svh */
`ifndef HELLO_PARAMS_SVH
`define HELLO_PARAMS_SVH

// --------------------
// Datapath widths
// --------------------
`define HELLO_DATA_W 32
`define HELLO_ADDR_W 32
// LED shadow and DIP switch lanes
`define HELLO_LED_W 16
`define HELLO_CNT_W 16
// Tick prescaler
`define HELLO_TICK_W 8

// --------------------
// Register map
// --------------------
`define HELLO_CMD_ADDR       32'h500
`define HELLO_VLED_ADDR      32'h504
`define HELLO_CNT_CTRL_ADDR  32'h508
`define HELLO_CNT_TICK_ADDR  32'h50C
`define HELLO_CNT_LOAD_ADDR  32'h510
`define HELLO_CNT_WMARK_ADDR 32'h514
`define HELLO_CNT_VALUE_ADDR 32'h518
// Any address outside the map reads as this
`define HELLO_UNMAPPED_VALUE 32'hDEAD_DEAD

`endif

/* rtl/hello_pkg.sv */
`default_nettype none

`include "hello_params.svh"

package hello_pkg;

  // Command opcodes, codes above RDC fold into MSC
  typedef enum logic [2:0] {
    DEL = 3'd0,
    ADD = 3'd1,
    SET = 3'd2,
    RDC = 3'd3,
    MSC = 3'd4
  } opcode_e;

  // Command word layout, opcode in the top bits
  typedef struct packed {
    opcode_e     opcode;
    logic        mode;
    logic [27:0] id;
  } cmd_t;

  // --------------------
  // Counter control
  // --------------------
  typedef struct packed {
    logic                     enable;
    logic                     oneshot;
    // Single-cycle pulses
    logic                     load;
    logic                     clear;
    logic [`HELLO_TICK_W-1:0] tick_value;
    logic [`HELLO_CNT_W-1:0]  load_value;
    logic [`HELLO_CNT_W-1:0]  watermark;
  } cnt_ctrl_t;

  typedef struct packed {
    logic [`HELLO_CNT_W-1:0] count;
    logic                    ge_watermark;
  } cnt_status_t;

  // Raw 3-bit code to opcode
  function automatic opcode_e decode_opcode(input logic [2:0] code);
    opcode_e op;
    case (code)
      3'd0:    op = DEL;
      3'd1:    op = ADD;
      3'd2:    op = SET;
      3'd3:    op = RDC;
      default: op = MSC;
    endcase
    return op;
  endfunction

endpackage

`default_nettype wire

/* rtl/hello_regs.sv */
`default_nettype none

`include "hello_params.svh"

module hello_regs (
  input  wire logic                     clk_main_a0,
  input  wire logic                     rst_main_n_sync,
  reg_bus_if.slave                      bus,
  input  wire hello_pkg::cnt_status_t   cnt_status,
  output hello_pkg::cnt_ctrl_t          cnt_ctrl,
  output logic [`HELLO_LED_W-1:0]       led_src
);

  import hello_pkg::*;

  cmd_t                     cmd_q;
  logic [`HELLO_DATA_W-1:0] cmd_word;
  logic [`HELLO_DATA_W-1:0] cmd_swapped;
  logic [`HELLO_DATA_W-1:0] rd_mux;

  // --------------------
  // Write decode
  // --------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      cmd_q    <= '{opcode: DEL, mode: 1'b0, id: '0};
      cnt_ctrl <= '0;
    end else begin
      // Load and clear last one cycle
      cnt_ctrl.load  <= 1'b0;
      cnt_ctrl.clear <= 1'b0;
      if (bus.wr_en) begin
        case (bus.wr_addr)
          `HELLO_CMD_ADDR: begin
            cmd_q.opcode <= decode_opcode(bus.wr_data[31:29]);
            cmd_q.mode   <= bus.wr_data[28];
            cmd_q.id     <= bus.wr_data[27:0];
          end
          `HELLO_CNT_CTRL_ADDR: begin
            cnt_ctrl.enable  <= bus.wr_data[0];
            cnt_ctrl.oneshot <= bus.wr_data[1];
            cnt_ctrl.load    <= bus.wr_data[2];
            cnt_ctrl.clear   <= bus.wr_data[3];
          end
          `HELLO_CNT_TICK_ADDR: begin
            cnt_ctrl.tick_value <= bus.wr_data[`HELLO_TICK_W-1:0];
          end
          `HELLO_CNT_LOAD_ADDR: begin
            cnt_ctrl.load_value <= bus.wr_data[`HELLO_CNT_W-1:0];
          end
          `HELLO_CNT_WMARK_ADDR: begin
            cnt_ctrl.watermark <= bus.wr_data[`HELLO_CNT_W-1:0];
          end
          // Unmapped writes are dropped
          default: begin
          end
        endcase
      end
    end
  end

  assign cmd_word = cmd_q;

  // Host sees the command with byte order reversed
  assign cmd_swapped = {cmd_word[7:0], cmd_word[15:8], cmd_word[23:16], cmd_word[31:24]};

  // LED shadow source, low half of the command
  assign led_src = cmd_word[`HELLO_LED_W-1:0];

  // --------------------
  // Read mux
  // --------------------
  always_comb begin
    rd_mux = '0;
    case (bus.rd_addr)
      `HELLO_CMD_ADDR: begin
        rd_mux = cmd_swapped;
      end
      `HELLO_VLED_ADDR: begin
        // Same value the LED shadow flop holds
        rd_mux[`HELLO_LED_W-1:0] = led_src;
      end
      `HELLO_CNT_CTRL_ADDR: begin
        rd_mux[1:0] = {cnt_ctrl.oneshot, cnt_ctrl.enable};
      end
      `HELLO_CNT_TICK_ADDR: begin
        rd_mux[`HELLO_TICK_W-1:0] = cnt_ctrl.tick_value;
      end
      `HELLO_CNT_LOAD_ADDR: begin
        rd_mux[`HELLO_CNT_W-1:0] = cnt_ctrl.load_value;
      end
      `HELLO_CNT_WMARK_ADDR: begin
        rd_mux[`HELLO_CNT_W-1:0] = cnt_ctrl.watermark;
      end
      `HELLO_CNT_VALUE_ADDR: begin
        // Count low, watermark flag just above it
        rd_mux[`HELLO_CNT_W-1:0] = cnt_status.count;
        rd_mux[`HELLO_CNT_W]     = cnt_status.ge_watermark;
      end
      default: begin
        rd_mux = `HELLO_UNMAPPED_VALUE;
      end
    endcase
  end

  // Read data held until the next read strobe
  always_ff @(posedge clk_main_a0) begin
    if (bus.rd_en) begin
      bus.rd_data <= rd_mux;
    end
  end

endmodule

`default_nettype wire

/* rtl/led_status.sv */
`default_nettype none

`include "hello_params.svh"

module led_status (
  input  wire logic                   clk_main_a0,
  input  wire logic                   rst_main_n_sync,
  input  wire logic [`HELLO_LED_W-1:0] led_src,
  input  wire logic [`HELLO_LED_W-1:0] vdip,
  output logic [`HELLO_LED_W-1:0]      vled
);

  logic [`HELLO_LED_W-1:0] vdip_q1;
  logic [`HELLO_LED_W-1:0] vdip_q2;
  logic [`HELLO_LED_W-1:0] shadow_q;

  // --------------------
  // DIP synchronizer
  // --------------------
  // Switches arrive from another domain, two flops
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q1 <= '0;
      vdip_q2 <= '0;
    end else begin
      vdip_q1 <= vdip;
      vdip_q2 <= vdip_q1;
    end
  end

  // Virtual LED shadow of the command low half
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      shadow_q <= '0;
    end else begin
      shadow_q <= led_src;
    end
  end

  // Output flop, LEDs masked by the switches
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled <= '0;
    end else begin
      vled <= shadow_q & vdip_q2;
    end
  end

endmodule

`default_nettype wire

/* rtl/reg_bus_if.sv */
`default_nettype none

`include "hello_params.svh"

// Simple register bus between the AXI-Lite front end and the register file
interface reg_bus_if (
  input wire logic clk_main_a0
);

  // Write strobe, register updates on the same edge
  logic                     wr_en;
  logic [`HELLO_ADDR_W-1:0] wr_addr;
  logic [`HELLO_DATA_W-1:0] wr_data;

  // Read strobe, data registered and valid one cycle later
  logic                     rd_en;
  logic [`HELLO_ADDR_W-1:0] rd_addr;
  logic [`HELLO_DATA_W-1:0] rd_data;

  modport master (
    input  clk_main_a0,
    output wr_en, wr_addr, wr_data,
    output rd_en, rd_addr,
    input  rd_data
  );

  modport slave (
    input  clk_main_a0,
    input  wr_en, wr_addr, wr_data,
    input  rd_en, rd_addr,
    output rd_data
  );

endinterface

`default_nettype wire

/* rtl/tick_counter.sv */
`default_nettype none

`include "hello_params.svh"

module tick_counter (
  input  wire logic                 clk_main_a0,
  input  wire logic                 rst_main_n_sync,
  input  wire hello_pkg::cnt_ctrl_t ctrl,
  output hello_pkg::cnt_status_t    status
);

  import hello_pkg::*;

  logic [`HELLO_TICK_W-1:0] presc_q;
  logic [`HELLO_TICK_W-1:0] presc_d;
  logic [`HELLO_CNT_W-1:0]  count_q;
  logic [`HELLO_CNT_W-1:0]  count_d;
  logic                     ge_q;
  logic                     tick;

  // --------------------
  // Prescaler
  // --------------------
  // Tick once every tick_value+1 enabled cycles
  assign tick = ctrl.enable && (presc_q >= ctrl.tick_value);

  always_comb begin
    presc_d = presc_q;
    if (ctrl.clear) begin
      presc_d = '0;
    end else if (tick) begin
      presc_d = '0;
    end else if (ctrl.enable) begin
      presc_d = presc_q + 1'b1;
    end
  end

  // Main count, clear over load over hold
  always_comb begin
    count_d = count_q;
    if (ctrl.clear) begin
      count_d = '0;
    end else if (ctrl.load) begin
      count_d = ctrl.load_value;
    end else if (tick) begin
      // One-shot parks at all ones
      if (!(ctrl.oneshot && (count_q == '1))) begin
        count_d = count_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      presc_q <= '0;
      count_q <= '0;
      ge_q    <= 1'b0;
    end else begin
      presc_q <= presc_d;
      count_q <= count_d;
      // Flag follows the new count, no extra lag
      ge_q    <= (count_d >= ctrl.watermark);
    end
  end

  assign status = '{count: count_q, ge_watermark: ge_q};

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --timescale 1ns/1ps \
  -f src.f --top-module tb_hello_top -o tb_hello_top

out=$(./obj_dir/tb_hello_top)
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1

/* src.f */
+incdir+rtl
rtl/hello_pkg.sv
rtl/reg_bus_if.sv
rtl/axil_reg_slave.sv
rtl/hello_regs.sv
rtl/led_status.sv
rtl/tick_counter.sv
rtl/cl_hello_top.sv
test/tb_hello_pkg.sv
test/tb_hello_top.sv

/* test/tb_hello_pkg.sv */
`default_nettype none

package tb_hello_pkg;

  timeunit 1ns;
  timeprecision 1ps;

  // --------------------
  // Test table
  // --------------------
  typedef enum int {
    K_WRITE,
    K_READ,
    // Read and keep the value for a later compare
    K_READ_SAVE,
    // Read that must differ from the kept value
    K_READ_DIFF,
    K_DIP,
    // Idle for wdata cycles
    K_IDLE,
    K_LED,
    // Closes the current test and prints its line
    K_END
  } kind_e;

  typedef struct {
    kind_e       kind;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_data;
    string       name;
  } step_t;

  int unsigned error_count = 0;

  // Random source state
  logic [31:0] lfsr_state = 32'h324448c1;

  // --------------------
  // Random bits
  // --------------------
  // Galois form, taps for x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_state[0]};
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
    end
    return val;
  endfunction

  // --------------------
  // Reference model
  // --------------------
  // Codes 4 to 7 are stored as MSC
  function automatic logic [2:0] fold_opcode(input logic [2:0] code);
    logic [2:0] op;
    op = (code > 3'd3) ? 3'd4 : code;
    return op;
  endfunction

  // Command readback, opcode folded, byte order reversed
  function automatic logic [31:0] cmd_readback(input logic [31:0] wr);
    logic [31:0] word;
    word = {fold_opcode(wr[31:29]), wr[28:0]};
    return {word[7:0], word[15:8], word[23:16], word[31:24]};
  endfunction

  // Compare and report
  task automatic check(input string sig, input logic [31:0] got,
                       input logic [31:0] exp_val);
    if (got !== exp_val) begin
      error_count++;
      $display("** Error at %0d ns: %s = 0x%08h, expected 0x%08h",
               $time, sig, got, exp_val);
    end
  endtask

  // Protocol trouble, no value to compare
  task automatic report_failure(input string what);
    error_count++;
    $display("Failure at %0d ns: %s", $time, what);
  endtask

endpackage

`default_nettype wire

/* test/tb_hello_top.sv */
`default_nettype none

`include "hello_params.svh"

module tb_hello_top;

  timeunit 1ns;
  timeprecision 1ps;

  import tb_hello_pkg::*;

  // Cycles allowed for any single handshake
  localparam int HANDSHAKE_LIMIT = 20;

  logic        clk_main_a0 = 1'b0;
  logic        rst_main_n_sync;
  logic        awvalid;
  logic [31:0] awaddr;
  logic        awready;
  logic        wvalid;
  logic [31:0] wdata;
  logic        wready;
  logic        bvalid;
  logic        bready;
  logic        arvalid;
  logic [31:0] araddr;
  logic        arready;
  logic        rvalid;
  logic [31:0] rdata;
  logic        rready;
  logic [15:0] vdip;
  logic [15:0] vled;

  step_t       steps[$];
  logic [31:0] saved_value;
  int unsigned tests_run;
  int unsigned tests_failed;
  int unsigned test_errors;
  bit          table_ready = 1'b0;

  always #5 clk_main_a0 = ~clk_main_a0;

  cl_hello_top i_cl_hello_top (.*);

  // --------------------
  // AXI-Lite master
  // --------------------
  // AW and W offered together, each dropped after its own handshake
  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
    logic aw_hs;
    logic w_hs;
    int   cycles;
    cycles = 0;
    @(negedge clk_main_a0);
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    while ((awvalid || wvalid) && cycles < HANDSHAKE_LIMIT) begin
      #1;
      aw_hs = awvalid && awready;
      w_hs  = wvalid && wready;
      @(negedge clk_main_a0);
      if (aw_hs) begin
        awvalid = 1'b0;
      end
      if (w_hs) begin
        wvalid = 1'b0;
      end
      cycles++;
    end
    if (awvalid || wvalid) begin
      report_failure($sformatf("write to 0x%0h was not accepted", addr));
      awvalid = 1'b0;
      wvalid  = 1'b0;
      return;
    end
    // Response phase
    bready = 1'b1;
    cycles = 0;
    #1;
    while (!bvalid && cycles < HANDSHAKE_LIMIT) begin
      @(negedge clk_main_a0);
      #1;
      cycles++;
    end
    if (!bvalid) begin
      report_failure($sformatf("no write response for 0x%0h", addr));
    end
    @(negedge clk_main_a0);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
    int cycles;
    data   = '0;
    cycles = 0;
    @(negedge clk_main_a0);
    arvalid = 1'b1;
    araddr  = addr;
    #1;
    while (!arready && cycles < HANDSHAKE_LIMIT) begin
      @(negedge clk_main_a0);
      #1;
      cycles++;
    end
    if (!arready) begin
      report_failure($sformatf("read of 0x%0h was not accepted", addr));
      arvalid = 1'b0;
      return;
    end
    // Address taken on the posedge in between
    @(negedge clk_main_a0);
    arvalid = 1'b0;
    rready  = 1'b1;
    cycles  = 0;
    #1;
    while (!rvalid && cycles < HANDSHAKE_LIMIT) begin
      @(negedge clk_main_a0);
      #1;
      cycles++;
    end
    if (rvalid) begin
      data = rdata;
    end else begin
      report_failure($sformatf("no read data for 0x%0h", addr));
    end
    @(negedge clk_main_a0);
    rready = 1'b0;
  endtask

  // --------------------
  // Table handling
  // --------------------
  function automatic void add_step(input kind_e kind, input logic [31:0] addr,
                                   input logic [31:0] wdat, input logic [31:0] exp_val,
                                   input string name);
    step_t s;
    s.kind     = kind;
    s.addr     = addr;
    s.wdata    = wdat;
    s.exp_data = exp_val;
    s.name     = name;
    steps.push_back(s);
  endfunction

  task automatic close_test(input string name);
    tests_run++;
    if (error_count != test_errors) begin
      tests_failed++;
      $display("Test %0d %s: FAIL", tests_run, name);
    end else begin
      $display("Test %0d %s: PASS", tests_run, name);
    end
    test_errors = error_count;
  endtask

  task automatic build_table();
    logic [31:0] cmd;
    logic [31:0] dip;
    logic [31:0] load_v;
    logic [31:0] wmark;
    // Command round trip, every raw opcode once
    for (int code = 0; code < 8; code++) begin
      cmd = lfsr_bits(32);
      cmd[31:29] = code[2:0];
      add_step(K_WRITE, `HELLO_CMD_ADDR, cmd, '0, "");
      add_step(K_READ, `HELLO_CMD_ADDR, '0, cmd_readback(cmd), "");
    end
    add_step(K_END, '0, '0, '0, "command round trip");
    // Virtual LED register
    for (int i = 0; i < 3; i++) begin
      cmd = lfsr_bits(32);
      add_step(K_WRITE, `HELLO_CMD_ADDR, cmd, '0, "");
      add_step(K_READ, `HELLO_VLED_ADDR, '0, {16'h0, cmd[15:0]}, "");
    end
    add_step(K_END, '0, '0, '0, "vled register");
    // LED port, shadow masked by the switches
    for (int i = 0; i < 3; i++) begin
      cmd = lfsr_bits(32);
      dip = lfsr_bits(16);
      add_step(K_WRITE, `HELLO_CMD_ADDR, cmd, '0, "");
      add_step(K_DIP, '0, dip, '0, "");
      add_step(K_IDLE, '0, 32'd10, '0, "");
      add_step(K_LED, '0, '0, {16'h0, cmd[15:0] & dip[15:0]}, "");
    end
    add_step(K_END, '0, '0, '0, "led output");
    // Counter load and clear with the counter stopped
    add_step(K_WRITE, `HELLO_CNT_CTRL_ADDR, 32'h0, '0, "");
    for (int i = 0; i < 3; i++) begin
      load_v = lfsr_bits(16);
      wmark  = lfsr_bits(16);
      // Flag clear, then flag set on equality
      if (i == 1) begin
        wmark = 32'hFFFF;
      end else if (i == 2) begin
        wmark = load_v;
      end
      add_step(K_WRITE, `HELLO_CNT_WMARK_ADDR, wmark, '0, "");
      add_step(K_WRITE, `HELLO_CNT_LOAD_ADDR, load_v, '0, "");
      add_step(K_WRITE, `HELLO_CNT_CTRL_ADDR, 32'h4, '0, "");
      add_step(K_READ, `HELLO_CNT_VALUE_ADDR, '0,
               {15'h0, load_v[15:0] >= wmark[15:0], load_v[15:0]}, "");
    end
    add_step(K_WRITE, `HELLO_CNT_CTRL_ADDR, 32'h8, '0, "");
    add_step(K_READ, `HELLO_CNT_VALUE_ADDR, '0, {15'h0, wmark[15:0] == 16'h0, 16'h0}, "");
    add_step(K_END, '0, '0, '0, "counter load and clear");
    // One-shot stops at all ones, free run wraps
    add_step(K_WRITE, `HELLO_CNT_TICK_ADDR, 32'h0, '0, "");
    add_step(K_WRITE, `HELLO_CNT_LOAD_ADDR, 32'hFFF0, '0, "");
    add_step(K_WRITE, `HELLO_CNT_CTRL_ADDR, 32'h4, '0, "");
    add_step(K_WRITE, `HELLO_CNT_CTRL_ADDR, 32'h3, '0, "");
    // Only the two level bits read back
    add_step(K_READ, `HELLO_CNT_CTRL_ADDR, '0, 32'h3, "");
    add_step(K_IDLE, '0, 32'd40, '0, "");
    add_step(K_READ, `HELLO_CNT_VALUE_ADDR, '0, 32'h1_FFFF, "");
    add_step(K_WRITE, `HELLO_CNT_CTRL_ADDR, 32'h0, '0, "");
    add_step(K_READ_SAVE, `HELLO_CNT_VALUE_ADDR, '0, '0, "");
    add_step(K_WRITE, `HELLO_CNT_CTRL_ADDR, 32'h1, '0, "");
    add_step(K_IDLE, '0, 32'd5, '0, "");
    add_step(K_WRITE, `HELLO_CNT_CTRL_ADDR, 32'h0, '0, "");
    add_step(K_READ_DIFF, `HELLO_CNT_VALUE_ADDR, '0, '0, "");
    add_step(K_END, '0, '0, '0, "one-shot saturation");
    // Unmapped reads, and writes that must not land anywhere
    add_step(K_READ, 32'h0, '0, `HELLO_UNMAPPED_VALUE, "");
    add_step(K_READ, 32'h4FC, '0, `HELLO_UNMAPPED_VALUE, "");
    add_step(K_READ, 32'h51C, '0, `HELLO_UNMAPPED_VALUE, "");
    add_step(K_READ, lfsr_bits(32) | 32'h1000, '0, `HELLO_UNMAPPED_VALUE, "");
    add_step(K_WRITE, 32'h600, lfsr_bits(32), '0, "");
    add_step(K_WRITE, 32'h0, lfsr_bits(32), '0, "");
    add_step(K_READ, `HELLO_CMD_ADDR, '0, cmd_readback(cmd), "");
    add_step(K_READ, `HELLO_CNT_LOAD_ADDR, '0, 32'hFFF0, "");
    add_step(K_READ, `HELLO_CNT_TICK_ADDR, '0, 32'h0, "");
    add_step(K_READ, `HELLO_CNT_WMARK_ADDR, '0, {16'h0, wmark[15:0]}, "");
    add_step(K_READ, `HELLO_CNT_CTRL_ADDR, '0, 32'h0, "");
    add_step(K_END, '0, '0, '0, "unmapped access");
  endtask

  task automatic run_step(input step_t s);
    logic [31:0] rd;
    case (s.kind)
      K_WRITE: begin
        axi_write(s.addr, s.wdata);
      end
      K_READ: begin
        axi_read(s.addr, rd);
        check($sformatf("rdata@0x%0h", s.addr), rd, s.exp_data);
      end
      K_READ_SAVE: begin
        axi_read(s.addr, saved_value);
      end
      K_READ_DIFF: begin
        axi_read(s.addr, rd);
        check("count_changed", {31'h0, rd !== saved_value}, 32'h1);
      end
      K_DIP: begin
        @(negedge clk_main_a0);
        vdip = s.wdata[15:0];
      end
      K_IDLE: begin
        repeat (s.wdata) @(negedge clk_main_a0);
      end
      K_LED: begin
        @(negedge clk_main_a0);
        check("vled", {16'h0, vled}, s.exp_data);
      end
      default: begin
        close_test(s.name);
      end
    endcase
  endtask

  // --------------------
  // Watchdog
  // --------------------
  initial begin
    wait (table_ready);
    repeat (steps.size() * 50 + 500) @(posedge clk_main_a0);
    $display("Watchdog expired, the test table did not finish in time");
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    rst_main_n_sync = 1'b0;
    awvalid         = 1'b0;
    awaddr          = '0;
    wvalid          = 1'b0;
    wdata           = '0;
    bready          = 1'b0;
    arvalid         = 1'b0;
    araddr          = '0;
    rready          = 1'b0;
    vdip            = '0;
    saved_value     = '0;
    tests_run       = 0;
    tests_failed    = 0;
    test_errors     = 0;
    build_table();
    table_ready = 1'b1;
    repeat (8) @(negedge clk_main_a0);
    rst_main_n_sync = 1'b1;
    @(negedge clk_main_a0);
    // Idle handshake state out of reset
    check("awready", {31'h0, awready}, 32'h1);
    check("arready", {31'h0, arready}, 32'h1);
    check("wready", {31'h0, wready}, 32'h0);
    check("bvalid", {31'h0, bvalid}, 32'h0);
    check("rvalid", {31'h0, rvalid}, 32'h0);
    close_test("reset state");
    foreach (steps[i]) begin
      run_step(steps[i]);
    end
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
